/* bench/tb_cache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cache;

	import cache_address_pkg::*;
	import cache_geometry_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_NS = NUM_TESTS * 64 * 8 * 2;

	logic clk;
	logic reset;
	addr_t address;
	logic read_signal;
	logic write_signal;
	line_t write_data;
	logic hit;
	logic read_hit;
	logic write_hit;
	logic halt_hit;
	byte_t read_data;

	// Reference model state
	logic m_valid [NUM_SETS][NUM_WAYS];
	tag_t m_tag [NUM_SETS][NUM_WAYS];
	halt_tag_t m_halt [NUM_SETS][NUM_WAYS];
	line_t m_line [NUM_SETS][NUM_WAYS];
	way_mask_t m_lru [NUM_WAYS];    // Global, row r all zero marks way r as least recent

	set_index_t a_set;
	halt_tag_t a_halt;
	tag_t a_tag;
	offset_t a_off;
	way_mask_t e_hit_mask;
	logic e_hit;
	logic e_halt_hit;
	byte_t e_read_data;
	logic e_update;
	int e_hit_way;
	int e_victim;
	int e_fill_way;

	string test_name;
	int mismatches;
	int total_errors;
	int pass_count;
	int fail_count;
	string first_what;
	logic [63:0] first_exp;
	logic [63:0] first_act;

	cache_top i_dut
	(
		.clk          (clk),
		.reset        (reset),
		.address      (address),
		.read_signal  (read_signal),
		.write_signal (write_signal),
		.write_data   (write_data),
		.hit          (hit),
		.read_hit     (read_hit),
		.write_hit    (write_hit),
		.halt_hit     (halt_hit),
		.read_data    (read_data)
	);

	always #4 clk = ~clk;

	assign a_off = address[OFFSET_LSB +: 3];
	assign a_set = address[SET_LSB +: 3];
	assign a_halt = address[HALT_LSB +: 4];
	assign a_tag = address[TAG_LSB +: 22];

	always_comb
	begin
		e_hit_mask = '0;
		e_halt_hit = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (m_halt[a_set][w] == a_halt)
			begin
				e_halt_hit = 1'b1;    // Validity plays no part in the halt match
				if (m_valid[a_set][w] && m_tag[a_set][w] == a_tag)
					e_hit_mask[w] = 1'b1;
			end
		end
		e_hit = |e_hit_mask;
		e_hit_way = -1;
		e_victim = -1;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (e_hit_mask[w] && e_hit_way < 0)
				e_hit_way = w;
			if (!m_valid[a_set][w] && e_victim < 0)
				e_victim = w;
		end
		// No free way, so fall back to the LRU matrix
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (m_lru[w] == '0 && e_victim < 0)
				e_victim = w;
		end
		if (e_victim < 0)
			e_victim = 0;
		e_read_data = e_hit ? m_line[a_set][e_hit_way][8 * a_off +: 8] : 8'h00;
		e_update = (read_signal || write_signal) && !(read_signal && e_hit);
		e_fill_way = e_hit ? e_hit_way : e_victim;
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
			begin
				for (int w = 0; w < NUM_WAYS; w++)
				begin
					m_valid[s][w] <= 1'b0;
					m_tag[s][w] <= '0;
					m_halt[s][w] <= '0;
				end
			end
			for (int r = 0; r < NUM_WAYS; r++)
				m_lru[r] <= '0;
		end
		else if (e_update)
		begin
			m_valid[a_set][e_fill_way] <= 1'b1;
			m_tag[a_set][e_fill_way] <= a_tag;
			m_halt[a_set][e_fill_way] <= a_halt;
			m_line[a_set][e_fill_way] <= write_data;
			for (int r = 0; r < NUM_WAYS; r++)
			begin
				if (r == e_fill_way)
					m_lru[r] <= ~(way_mask_t'(1) << r);
				else
					m_lru[r][e_fill_way] <= 1'b0;
			end
		end
	end

	task automatic report_mismatch(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		$display("FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
		if (mismatches == 0)
		begin
			first_what = what;
			first_exp = exp;
			first_act = act;
		end
		mismatches++;
		total_errors++;
	endtask

	// Outputs settle between the drive point and the falling edge
	hit_check: assert property (@(negedge clk) disable iff (reset) hit === e_hit)
		else report_mismatch("hit", e_hit, hit);
	read_hit_check: assert property (@(negedge clk) disable iff (reset)
		read_hit === (e_hit && read_signal))
		else report_mismatch("read_hit", e_hit && read_signal, read_hit);
	write_hit_check: assert property (@(negedge clk) disable iff (reset)
		write_hit === (e_hit && write_signal))
		else report_mismatch("write_hit", e_hit && write_signal, write_hit);
	halt_hit_check: assert property (@(negedge clk) disable iff (reset)
		halt_hit === e_halt_hit)
		else report_mismatch("halt_hit", e_halt_hit, halt_hit);
	read_data_check: assert property (@(negedge clk) disable iff (reset)
		read_data === e_read_data)
		else report_mismatch("read_data", e_read_data, read_data);

	task automatic expect_value(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act === exp) else report_mismatch(what, exp, act);
	endtask

	task automatic drive(input addr_t addr, input logic rd, input logic wr, input line_t data);
		address = addr;
		read_signal = rd;
		write_signal = wr;
		write_data = data;
	endtask

	task automatic access(input addr_t addr, input logic rd, input logic wr, input line_t data);
		@(posedge clk);
		#1;
		drive(addr, rd, wr, data);
	endtask

	function automatic addr_t model_addr(input int set, input int way, input int off);
		return {m_tag[set][way], m_halt[set][way], 3'(set), 3'(off)};
	endfunction

	function automatic line_t random_line();
		return {$urandom, $urandom};
	endfunction

	task automatic read_back_set(input int set);
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			@(posedge clk);
			#1;
			drive(model_addr(set, w, w), 1'b1, 1'b0, '0);
			@(negedge clk);
			expect_value("read back hit", 1, read_hit);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		mismatches = 0;
	endtask

	task automatic finish_test();
		#1;    // Lets the assertions of the last falling edge count for this test
		if (mismatches == 0)
		begin
			$display("PASS %s", test_name);
			pass_count++;
		end
		else
		begin
			$display("FAILED %s: %s expected %0h actual %0h, %0d mismatches", test_name,
				first_what, first_exp, first_act, mismatches);
			fail_count++;
		end
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests completed");
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		addr_t addrs [NUM_WAYS];
		addr_t addr;
		line_t line;
		int victim;
		clk = 1'b0;
		reset = 1'b1;
		drive('0, 1'b0, 1'b0, '0);
		test_name = "reset";
		mismatches = 0;
		total_errors = 0;
		pass_count = 0;
		fail_count = 0;
		void'($urandom(89));
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		start_test("reset_read_miss");
		for (int i = 0; i < 3; i++)
		begin
			// Sets 0, 3 and 6 with halt tags 0, 5 and 10
			addr = {22'(7 + i), 4'(5 * i), 3'(3 * i), 3'd1};
			access(addr, 1'b1, 1'b0, random_line());
			@(negedge clk);
			expect_value("read_hit after reset", 0, read_hit);
			expect_value("halt_hit after reset", i == 0, halt_hit);
		end
		finish_test();

		start_test("write_then_read");
		addr = {22'h2a5, 4'd3, 3'd1, 3'd0};
		line = random_line();
		access(addr, 1'b0, 1'b1, line);
		for (int off = 0; off < LINE_BYTES; off++)
		begin
			access(addr | 32'(off), 1'b1, 1'b0, '0);
			@(negedge clk);
			expect_value("read_hit", 1, read_hit);
			expect_value("byte", line[8 * off +: 8], read_data);
		end
		finish_test();

		start_test("fill_full_set");
		for (int i = 0; i < NUM_WAYS; i++)
		begin
			addrs[i] = {22'(100 + i), 4'(i), 3'd2, 3'd0};
			access(addrs[i], 1'b0, 1'b1, random_line());
			@(negedge clk);
			expect_value("write_hit on fill", 0, write_hit);
		end
		read_back_set(2);
		finish_test();

		start_test("lru_eviction");
		access({22'd200, 4'd9, 3'd2, 3'd0}, 1'b0, 1'b1, random_line());
		@(negedge clk);
		victim = e_fill_way;
		addr = model_addr(2, victim, 0);    // Entry about to be replaced
		read_back_set(2);
		access(addr, 1'b1, 1'b0, random_line());
		@(negedge clk);
		expect_value("evicted read_hit", 0, read_hit);
		finish_test();

		start_test("write_hit_in_place");
		line = random_line();
		@(posedge clk);
		#1;
		drive(model_addr(2, 5, 0), 1'b0, 1'b1, line);
		@(negedge clk);
		expect_value("write_hit", 1, write_hit);
		read_back_set(2);
		@(posedge clk);
		#1;
		drive(model_addr(2, 5, 3), 1'b1, 1'b0, '0);
		@(negedge clk);
		expect_value("rewritten byte", line[31:24], read_data);
		finish_test();

		start_test("halt_mismatch");
		@(posedge clk);
		#1;
		addr = model_addr(2, 3, 0);
		drive(addr ^ (32'h5 << HALT_LSB), 1'b1, 1'b0, random_line());
		@(negedge clk);
		expect_value("halted read_hit", 0, read_hit);
		// The miss above allocated another way, way 3 is still in place
		access(addr, 1'b1, 1'b0, '0);
		@(negedge clk);
		expect_value("unhalted read_hit", 1, read_hit);
		access({22'h3ff, 4'hc, 3'd2, 3'd4}, 1'b1, 1'b0, random_line());
		@(negedge clk);
		expect_value("unknown read_hit", 0, read_hit);
		finish_test();

		@(posedge clk);
		#1;
		drive('0, 1'b0, 1'b0, '0);
		$display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && total_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
source/cache_address_pkg.sv
source/cache_geometry_pkg.sv
source/way_halt_filter.sv
source/way_store.sv
source/hit_select.sv
source/replacement_control.sv
source/cache_top.sv
bench/tb_cache.sv

/* source/cache_address_pkg.sv */
`default_nettype none

package cache_address_pkg;

	// Byte address as seen on the cache port
	typedef logic [31:0] addr_t;

	typedef logic [21:0] tag_t;
	typedef logic [3:0] halt_tag_t;      // Low tag bits kept per way for halting
	typedef logic [2:0] set_index_t;
	typedef logic [2:0] offset_t;        // Byte within the line

	// Lowest bit of each field in addr_t
	localparam int OFFSET_LSB = 0;
	localparam int SET_LSB = 3;
	localparam int HALT_LSB = 6;
	localparam int TAG_LSB = 10;

endpackage

`default_nettype wire

/* source/cache_geometry_pkg.sv */
`default_nettype none

package cache_geometry_pkg;

	localparam int NUM_WAYS = 8;
	localparam int NUM_SETS = 8;
	localparam int LINE_BYTES = 8;

	typedef logic [2:0] way_index_t;

	// One bit per way, bit 0 is way 0
	typedef logic [NUM_WAYS-1:0] way_mask_t;

	typedef logic [7:0] byte_t;
	typedef logic [LINE_BYTES*8-1:0] line_t;    // Byte 0 sits in the low bits

endpackage

`default_nettype wire

/* source/cache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_top
(
	input wire clk,
	input wire reset,
	input wire cache_address_pkg::addr_t address,
	input wire read_signal,
	input wire write_signal,
	input wire cache_geometry_pkg::line_t write_data,
	output logic hit,
	output logic read_hit,
	output logic write_hit,
	output logic halt_hit,
	output cache_geometry_pkg::byte_t read_data
);

	import cache_address_pkg::*;
	import cache_geometry_pkg::*;

	tag_t tag;
	halt_tag_t halt_tag;
	set_index_t set_index;
	offset_t offset;

	way_mask_t halt_match;
	way_mask_t set_valid;
	way_mask_t hit_mask;
	way_mask_t fill_mask;
	tag_t [NUM_WAYS-1:0] set_tags;
	line_t [NUM_WAYS-1:0] set_lines;
	logic update;

	assign offset = address[OFFSET_LSB +: $bits(offset_t)];
	assign set_index = address[SET_LSB +: $bits(set_index_t)];
	assign halt_tag = address[HALT_LSB +: $bits(halt_tag_t)];
	assign tag = address[TAG_LSB +: $bits(tag_t)];

	way_halt_filter i_way_halt_filter
	(
		.clk        (clk),
		.reset      (reset),
		.set_index  (set_index),
		.halt_tag   (halt_tag),
		.fill_mask  (fill_mask),
		.update     (update),
		.halt_match (halt_match),
		.halt_hit   (halt_hit)
	);

	way_store i_way_store
	(
		.clk        (clk),
		.reset      (reset),
		.set_index  (set_index),
		.tag        (tag),
		.write_data (write_data),
		.fill_mask  (fill_mask),
		.update     (update),
		.set_valid  (set_valid),
		.set_tags   (set_tags),
		.set_lines  (set_lines)
	);

	hit_select i_hit_select
	(
		.tag          (tag),
		.offset       (offset),
		.read_signal  (read_signal),
		.write_signal (write_signal),
		.halt_match   (halt_match),
		.set_valid    (set_valid),
		.set_tags     (set_tags),
		.set_lines    (set_lines),
		.hit_mask     (hit_mask),
		.hit          (hit),
		.read_hit     (read_hit),
		.write_hit    (write_hit),
		.read_data    (read_data)
	);

	// Picks the way that both arrays write on the next edge
	replacement_control i_replacement_control
	(
		.clk          (clk),
		.reset        (reset),
		.read_signal  (read_signal),
		.write_signal (write_signal),
		.set_valid    (set_valid),
		.hit_mask     (hit_mask),
		.fill_mask    (fill_mask),
		.update       (update)
	);

endmodule

`default_nettype wire

/* source/hit_select.sv */
`timescale 1ns/1ns
`default_nettype none

module hit_select
(
	input wire cache_address_pkg::tag_t tag,
	input wire cache_address_pkg::offset_t offset,
	input wire read_signal,
	input wire write_signal,
	input wire cache_geometry_pkg::way_mask_t halt_match,
	input wire cache_geometry_pkg::way_mask_t set_valid,
	input wire cache_address_pkg::tag_t [cache_geometry_pkg::NUM_WAYS-1:0] set_tags,
	input wire cache_geometry_pkg::line_t [cache_geometry_pkg::NUM_WAYS-1:0] set_lines,
	output cache_geometry_pkg::way_mask_t hit_mask,
	output logic hit,
	output logic read_hit,
	output logic write_hit,
	output cache_geometry_pkg::byte_t read_data
);

	import cache_geometry_pkg::*;

	way_index_t hit_way;
	byte_t [LINE_BYTES-1:0] hit_bytes;

	// Halted ways drop out before the full tag compare
	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
			hit_mask[w] = halt_match[w] & set_valid[w] & (set_tags[w] == tag);
	end

	assign hit = |hit_mask;
	assign read_hit = hit & read_signal;
	assign write_hit = hit & write_signal;

	// Lowest hitting way wins if more than one matches
	always_comb
	begin
		hit_way = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--)
		begin
			if (hit_mask[w])
				hit_way = way_index_t'(w);
		end
	end

	assign hit_bytes = set_lines[hit_way];
	assign read_data = hit ? hit_bytes[offset] : '0;

endmodule

`default_nettype wire

/* source/replacement_control.sv */
`timescale 1ns/1ns
`default_nettype none

module replacement_control
(
	input wire clk,
	input wire reset,
	input wire read_signal,
	input wire write_signal,
	input wire cache_geometry_pkg::way_mask_t set_valid,
	input wire cache_geometry_pkg::way_mask_t hit_mask,
	output cache_geometry_pkg::way_mask_t fill_mask,
	output logic update
);

	import cache_geometry_pkg::*;

	// Global matrix shared by all sets, row r set means way r was used after others
	way_mask_t lru [NUM_WAYS];
	way_mask_t row_empty;
	way_index_t victim;
	way_index_t hit_way;
	way_index_t touched;
	logic any_hit;

	assign any_hit = |hit_mask;

	// Everything except a read hit writes the arrays
	assign update = (read_signal | write_signal) & ~(read_signal & any_hit);

	always_comb
	begin
		for (int r = 0; r < NUM_WAYS; r++)
			row_empty[r] = ~|lru[r];    // An all zero row marks the least recently used way
	end

	always_comb
	begin
		victim = '0;
		hit_way = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--)
		begin
			if (row_empty[w])
				victim = way_index_t'(w);
		end
		// Invalid ways override the matrix choice
		for (int w = NUM_WAYS - 1; w >= 0; w--)
		begin
			if (!set_valid[w])
				victim = way_index_t'(w);
			if (hit_mask[w])
				hit_way = way_index_t'(w);
		end
	end

	assign touched = any_hit ? hit_way : victim;
	assign fill_mask = update ? (way_mask_t'(1'b1) << touched) : '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int r = 0; r < NUM_WAYS; r++)
				lru[r] <= '0;
		end
		else if (update)
		begin
			for (int r = 0; r < NUM_WAYS; r++)
			begin
				if (way_index_t'(r) == touched)
					lru[r] <= ~fill_mask;      // Own row to ones, own bit stays clear
				else
					lru[r][touched] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* source/way_halt_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module way_halt_filter
(
	input wire clk,
	input wire reset,
	input wire cache_address_pkg::set_index_t set_index,
	input wire cache_address_pkg::halt_tag_t halt_tag,
	input wire cache_geometry_pkg::way_mask_t fill_mask,
	input wire update,
	output cache_geometry_pkg::way_mask_t halt_match,
	output logic halt_hit
);

	import cache_address_pkg::*;
	import cache_geometry_pkg::*;

	halt_tag_t halt_mem [NUM_SETS][NUM_WAYS];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
			begin
				for (int w = 0; w < NUM_WAYS; w++)
					halt_mem[s][w] <= '0;
			end
		end
		else if (update)
		begin
			// The filled way learns the halt tag of the new line
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				if (fill_mask[w])
					halt_mem[set_index][w] <= halt_tag;
			end
		end
	end

	// A way with a different halt tag cannot hit, so its tag compare is skipped
	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
			halt_match[w] = (halt_mem[set_index][w] == halt_tag);
	end

	assign halt_hit = |halt_match;    // Valid bits are not considered here

endmodule

`default_nettype wire

/* source/way_store.sv */
`timescale 1ns/1ns
`default_nettype none

module way_store
(
	input wire clk,
	input wire reset,
	input wire cache_address_pkg::set_index_t set_index,
	input wire cache_address_pkg::tag_t tag,
	input wire cache_geometry_pkg::line_t write_data,
	input wire cache_geometry_pkg::way_mask_t fill_mask,
	input wire update,
	output cache_geometry_pkg::way_mask_t set_valid,
	output cache_address_pkg::tag_t [cache_geometry_pkg::NUM_WAYS-1:0] set_tags,
	output cache_geometry_pkg::line_t [cache_geometry_pkg::NUM_WAYS-1:0] set_lines
);

	import cache_address_pkg::*;
	import cache_geometry_pkg::*;

	way_mask_t valid_mem [NUM_SETS];     // Indexed by set, one bit per way
	tag_t tag_mem [NUM_SETS][NUM_WAYS];
	line_t line_mem [NUM_SETS][NUM_WAYS];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
			begin
				valid_mem[s] <= '0;
				for (int w = 0; w < NUM_WAYS; w++)
					tag_mem[s][w] <= '0;
			end
		end
		else if (update)
		begin
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				if (fill_mask[w])
				begin
					valid_mem[set_index][w] <= 1'b1;
					tag_mem[set_index][w] <= tag;
				end
			end
		end
	end

	// A write hit and a miss fill both land here with the full line
	always_ff @(posedge clk)
	begin
		if (update)
		begin
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				if (fill_mask[w])
					line_mem[set_index][w] <= write_data;
			end
		end
	end

	always_comb
	begin
		set_valid = valid_mem[set_index];
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			set_tags[w] = tag_mem[set_index][w];
			set_lines[w] = line_mem[set_index][w];
		end
	end

endmodule

`default_nettype wire
